//--- src.f
+incdir+source
+incdir+tests
source/prog_rom_pkg.sv
source/prog_rom_loader.sv
source/prog_rom_bank.sv
source/prog_rom_read_mux.sv
source/gauntlet_prog_rom.sv
tests/tb_gauntlet_prog_rom.sv

//--- Makefile
# Verilator build and run of the program ROM testbench
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_gauntlet_prog_rom
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j $(JOBS)

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Test OK" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/tb_prog_rom_checks.svh
// Reference model of the program banks, expected-value functions and typed compare tasks
`ifndef TB_PROG_ROM_CHECKS_SVH
`define TB_PROG_ROM_CHECKS_SVH

// ########################################
// Reference model
// ########################################

word_t model_mem [`PROG_BANKS * `BANK_WORDS];  // Banks back to back
byte_t model_prev;                             // Last accepted byte

function automatic void model_clear();
	foreach (model_mem[i])
		model_mem[i] = '0;
	model_prev = '0;  // Matches the held byte after reset
endfunction

// Byte belongs to the ROM image
function automatic bit byte_taken(logic active, logic wr, logic [7:0] index);
	return active && wr && (index == 8'd0);
endfunction

function automatic bit slot_in_region(int unsigned slot);
	return (slot >= `PROG_BASE_BANK) && (slot < `PROG_BASE_BANK + `PROG_BANKS);
endfunction

// Bank write expected one cycle after this byte
function automatic bank_mask_t expected_mask(logic active, logic wr, logic [7:0] index,
	dl_addr_u addr);
	bank_mask_t  mask;
	int unsigned slot;
	mask = '0;
	slot = 32'(addr.fld.slot);
	if (byte_taken(active, wr, index) && addr.fld.lane) begin
		for (int i = 0; i < `PROG_BANKS; i++)
			mask[i] = (slot == `PROG_BASE_BANK + i);
	end
	return mask;
endfunction

// Pairing rule, earlier byte goes high
function automatic void model_download(logic active, logic wr, logic [7:0] index,
	dl_addr_u addr, byte_t data);
	int unsigned slot;
	int unsigned idx;
	if (!byte_taken(active, wr, index))
		return;
	slot = 32'(addr.fld.slot);
	if (addr.fld.lane && slot_in_region(slot)) begin
		idx = (slot - `PROG_BASE_BANK) * `BANK_WORDS + 32'(addr.fld.offset);
		model_mem[idx] = {model_prev, data};
	end
	model_prev = data;  // Every accepted byte, any slot
endfunction

// CPU view, slots 6 and 7 read as zero
function automatic word_t expected_word(cpu_addr_t addr);
	int unsigned bank;
	int unsigned offs;
	bank = 32'(addr[`CPU_AW-1:`BANK_AW]);
	offs = 32'(addr[`BANK_AW-1:0]);
	if (bank >= `PROG_BANKS)
		return '0;
	return model_mem[bank * `BANK_WORDS + offs];
endfunction

// ########################################
// Compare tasks
// ########################################

task automatic check_word(string name, word_t got, word_t exp);
	if (got !== exp)
		abort_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
endtask

task automatic check_valid(bit got, bit exp);
	if (got != exp)
		abort_run($sformatf("Mismatch at %0t: prog_valid got %0b expected %0b",
			$time, got, exp));
endtask

task automatic check_mask(bank_mask_t got, bank_mask_t exp);
	if (got !== exp)
		abort_run($sformatf("Mismatch at %0t: bank_we got %b expected %b", $time, got, exp));
endtask

`endif

//--- tests/tb_gauntlet_prog_rom.sv
// Testbench for the program ROM top level, with stimulus, monitor and timeout
`timescale 1ns/1ps
`include "prog_rom_macros.svh"

module tb_gauntlet_prog_rom
	import prog_rom_pkg::*;
();

	// ########################################
	// Run length
	// ########################################

	localparam int unsigned TOTAL_WORDS = `PROG_BANKS * `BANK_WORDS;
	localparam int unsigned N_LANE0     = 16;   // Lone even bytes after reset
	localparam int unsigned N_IGNORED   = 24;   // Offsets hit by ignored bytes
	localparam int unsigned N_UNMAPPED  = 16;
	localparam int unsigned N_BURST     = 64;
	localparam int unsigned N_BYTES     = N_LANE0 + 2 * TOTAL_WORDS + 8 * N_IGNORED;
	localparam int unsigned N_READS     = TOTAL_WORDS + N_UNMAPPED + N_IGNORED + N_BURST;
	localparam int unsigned CYCLE_LIMIT = 2 * (N_BYTES + N_READS + 200);
	localparam int unsigned BASE        = `PROG_BASE_BANK;

	logic       clk_sys;
	logic       rst_n;
	logic       dl_active;
	logic       dl_wr;
	logic [7:0] dl_index;
	dl_addr_u   dl_addr;
	byte_t      dl_data;
	logic       prog_rd;
	cpu_addr_t  prog_addr;
	word_t      prog_data;
	logic       prog_valid;

	word_t       exp_q [$];            // Expected words in issue order
	cpu_addr_t   readback [$];
	logic [1:0]  rd_pipe = '0;         // Read strobes of the last two cycles
	bank_mask_t  exp_we = '0;          // Bank write due at the next check
	int unsigned cycle_count = 0;
	int unsigned order [TOTAL_WORDS];  // Shuffled word indices

	gauntlet_prog_rom uut (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.dl_active  (dl_active),
		.dl_wr      (dl_wr),
		.dl_index   (dl_index),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.prog_rd    (prog_rd),
		.prog_addr  (prog_addr),
		.prog_data  (prog_data),
		.prog_valid (prog_valid)
	);

	task automatic abort_run(string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	`include "tb_prog_rom_checks.svh"

	// ########################################
	// Clock, timeout, monitor
	// ########################################

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;  // 50 MHz
	end

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
			abort_run($sformatf("Timeout, run still busy after %0d cycles", cycle_count));
	end

	// Sampled on the falling edge once outputs settle
	always @(negedge clk_sys) begin
		if (rst_n === 1'b1) begin
			check_mask(uut.bank_we, exp_we);
			exp_we = expected_mask(dl_active, dl_wr, dl_index, dl_addr);
			model_download(dl_active, dl_wr, dl_index, dl_addr, dl_data);
			check_valid(prog_valid, rd_pipe[1]);  // Two cycles after the strobe
			if (prog_valid) begin
				if (exp_q.size() == 0)
					abort_run("prog_valid seen with no read outstanding");
				check_word("prog_data", prog_data, exp_q.pop_front());
			end
			rd_pipe = {rd_pipe[0], prog_rd};
		end
	end

	// ########################################
	// Stimulus tasks
	// ########################################

	function automatic dl_addr_u make_dl_addr(int unsigned slot, int unsigned offs, bit lane);
		dl_addr_u a;
		a.raw        = '0;
		a.fld.slot   = `SLOT_W'(slot);
		a.fld.offset = bank_addr_t'(offs);
		a.fld.lane   = lane;
		return a;
	endfunction

	function automatic cpu_addr_t cpu_addr(int unsigned bank, int unsigned offs);
		return {3'(bank), bank_addr_t'(offs)};
	endfunction

	task automatic idle_cycles(int unsigned n);
		repeat (n) begin
			@(posedge clk_sys);
			#2;
			dl_wr   = 1'b0;
			prog_rd = 1'b0;
		end
	endtask

	task automatic send_byte(logic active, logic [7:0] index, dl_addr_u addr, byte_t data);
		@(posedge clk_sys);
		#2;
		prog_rd   = 1'b0;
		dl_active = active;
		dl_wr     = 1'b1;
		dl_index  = index;
		dl_addr   = addr;
		dl_data   = data;
	endtask

	// Even then odd byte of one word
	task automatic send_pair(logic active, logic [7:0] index, int unsigned slot,
		int unsigned offs);
		send_byte(active, index, make_dl_addr(slot, offs, 1'b0), byte_t'($urandom));
		send_byte(active, index, make_dl_addr(slot, offs, 1'b1), byte_t'($urandom));
	endtask

	task automatic issue_read(cpu_addr_t addr);
		@(posedge clk_sys);
		#2;
		dl_wr     = 1'b0;
		prog_rd   = 1'b1;
		prog_addr = addr;
		exp_q.push_back(expected_word(addr));
	endtask

	// Wait for every read to come back
	task automatic drain_reads();
		idle_cycles(1);
		while (exp_q.size() != 0)
			@(posedge clk_sys);
	endtask

	// ########################################
	// Test sequence
	// ########################################

	initial begin
		int unsigned j;
		int unsigned tmp;
		int unsigned bank;
		int unsigned offs;
		void'($urandom(69));
		rst_n     = 1'b0;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		dl_index  = 8'd0;
		dl_addr   = '0;
		dl_data   = '0;
		prog_rd   = 1'b0;
		prog_addr = '0;
		model_clear();
		repeat (2) @(posedge clk_sys);
		#2 rst_n = 1'b1;

		// Quiet outputs after reset and no write from even bytes
		idle_cycles(8);
		for (int k = 0; k < N_LANE0; k++) begin
			bank = $urandom_range(`PROG_BANKS - 1, 0);
			offs = $urandom_range(`BANK_WORDS - 1, 0);
			send_byte(1'b1, 8'd0, make_dl_addr(BASE + bank, offs, 1'b0), byte_t'($urandom));
		end
		idle_cycles(2);

		// Full download over every program slot
		for (int s = 0; s < `PROG_BANKS; s++) begin
			for (int o = 0; o < `BANK_WORDS; o++)
				send_pair(1'b1, 8'd0, BASE + s, o);
		end
		idle_cycles(2);

		// Shuffled readback with one read per cycle
		for (int i = 0; i < TOTAL_WORDS; i++)
			order[i] = i;
		for (int i = TOTAL_WORDS - 1; i > 0; i--) begin
			j        = $urandom_range(i, 0);
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < TOTAL_WORDS; i++)
			issue_read(cpu_addr(order[i] / `BANK_WORDS, order[i] % `BANK_WORDS));
		drain_reads();

		// Slots 6 and 7 have no bank
		for (int k = 0; k < N_UNMAPPED; k++) begin
			issue_read(cpu_addr(`PROG_BANKS + k % 2, $urandom_range(`BANK_WORDS - 1, 0)));
			idle_cycles(1);
		end
		drain_reads();

		// Bytes that must not reach a bank
		for (int k = 0; k < N_IGNORED; k++) begin
			bank = $urandom_range(`PROG_BANKS - 1, 0);
			offs = $urandom_range(`BANK_WORDS - 1, 0);
			send_pair(1'b1, 8'($urandom_range(255, 1)), BASE + bank, offs);  // Other image
			send_pair(1'b0, 8'd0, BASE + bank, offs);           // Loader idle
			send_pair(1'b1, 8'd0, BASE - 1, offs);              // Below region
			send_pair(1'b1, 8'd0, BASE + `PROG_BANKS, offs);    // Above region
			readback.push_back(cpu_addr(bank, offs));
		end
		idle_cycles(2);
		foreach (readback[i])
			issue_read(readback[i]);
		drain_reads();

		// Back-to-back reads over all eight slots
		for (int k = 0; k < N_BURST; k++)
			issue_read(cpu_addr_t'($urandom));
		drain_reads();

		idle_cycles(4);
		if (exp_q.size() == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			abort_run("Reads still outstanding at the end of the run");
		end
	end

endmodule

//--- source/gauntlet_prog_rom.sv
// Program ROM top level with loader, bank array and read multiplexer
`timescale 1ns/1ps
`include "prog_rom_macros.svh"

module gauntlet_prog_rom
	import prog_rom_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,

	// ROM loader byte stream
	input  logic       dl_active,
	input  logic       dl_wr,
	input  logic [7:0] dl_index,
	input  dl_addr_u   dl_addr,
	input  byte_t      dl_data,

	// CPU program fetch
	input  logic       prog_rd,
	input  cpu_addr_t  prog_addr,
	output word_t      prog_data,
	output logic       prog_valid
);

	bank_mask_t bank_we;                  // One-hot from loader
	bank_addr_t wr_addr;
	word_t      wr_data;                  // Common write word
	bank_addr_t rd_addr;
	word_t      bank_q [`PROG_BANKS];     // Per-bank read data

	// ########################################
	// Download side
	// ########################################

	prog_rom_loader u_loader (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_index  (dl_index),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.bank_we   (bank_we),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data)
	);

	// One bank per enable bit
	for (genvar g = 0; g < `PROG_BANKS; g++) begin : g_bank
		prog_rom_bank u_bank (
			.clk_sys (clk_sys),
			.bank_we (bank_we[g]),
			.wr_addr (wr_addr),
			.wr_data (wr_data),
			.rd_addr (rd_addr),
			.bank_q  (bank_q[g])
		);
	end

	// ########################################
	// CPU side
	// ########################################

	prog_rom_read_mux u_read_mux (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.prog_rd    (prog_rd),
		.prog_addr  (prog_addr),
		.rd_addr    (rd_addr),
		.bank_q     (bank_q),
		.prog_data  (prog_data),
		.prog_valid (prog_valid)
	);

endmodule

//--- source/prog_rom_read_mux.sv
// CPU address decode, bank select alignment and output register
`timescale 1ns/1ps
`include "prog_rom_macros.svh"

module prog_rom_read_mux
	import prog_rom_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       prog_rd,                // CPU read strobe
	input  cpu_addr_t  prog_addr,
	output bank_addr_t rd_addr,                // Shared by all banks
	input  word_t      bank_q [`PROG_BANKS],
	output word_t      prog_data,
	output logic       prog_valid              // Two clocks after prog_rd
);

	bank_idx_t rd_bank;    // Slot of the incoming read
	bank_idx_t bank_d1;    // Same, aligned with RAM output
	logic      rd_d1;      // Strobe, aligned with RAM output
	word_t     sel_word;

	// ########################################
	// Address split
	// ########################################

	assign rd_addr = prog_addr[`BANK_AW-1:0];          // Offset straight to RAM
	assign rd_bank = prog_addr[`CPU_AW-1:`BANK_AW];

	// Stage 1, wait out the RAM read
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bank_d1 <= '0;
			rd_d1   <= 1'b0;
		end else begin
			bank_d1 <= rd_bank;
			rd_d1   <= prog_rd;
		end
	end

	// ########################################
	// Select and output
	// ########################################

	// Slots past the last bank read as zero
	always_comb begin
		sel_word = '0;
		for (int i = 0; i < `PROG_BANKS; i++) begin
			if (bank_d1 == 3'(i))
				sel_word = bank_q[i];
		end
	end

	// Stage 2
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			prog_data  <= '0;
			prog_valid <= 1'b0;
		end else begin
			prog_valid <= rd_d1;
			if (rd_d1)
				prog_data <= sel_word;  // Holds between reads
		end
	end

	// Fixed two cycle latency, both directions
	a_rd_latency: assert property (@(posedge clk_sys) disable iff (!rst_n)
		prog_rd |-> ##2 prog_valid);

	a_valid_cause: assert property (@(posedge clk_sys) disable iff (!rst_n)
		prog_valid |-> $past(prog_rd, 2));

endmodule

//--- source/prog_rom_bank.sv
// One dual-port program ROM bank with registered read
`timescale 1ns/1ps
`include "prog_rom_macros.svh"

module prog_rom_bank
	import prog_rom_pkg::*;
(
	input  logic       clk_sys,
	input  logic       bank_we,  // This bank's write enable
	input  bank_addr_t wr_addr,
	input  word_t      wr_data,
	input  bank_addr_t rd_addr,
	output word_t      bank_q
);

	// ########################################
	// Storage
	// ########################################

	// Holds one even/odd ROM chip pair
	word_t mem [`BANK_WORDS];

	// Loader side write port
	always_ff @(posedge clk_sys) begin
		if (bank_we)
			mem[wr_addr] <= wr_data;
	end

	// CPU side read, one cycle latency
	// Same word written this edge reads back the old value
	always_ff @(posedge clk_sys) begin
		bank_q <= mem[rd_addr];
	end

	// ########################################
	// Checks
	// ########################################

	// Loader must present a clean address with the strobe
	a_wr_addr_known: assert property (@(posedge clk_sys)
		bank_we |-> !$isunknown(wr_addr));

endmodule

//--- source/prog_rom_loader.sv
// Download byte pairing and program bank write decode
`timescale 1ns/1ps
`include "prog_rom_macros.svh"

module prog_rom_loader
	import prog_rom_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       dl_active,  // Download in progress
	input  logic       dl_wr,      // One strobe per byte
	input  logic [7:0] dl_index,   // 0 is the ROM image
	input  dl_addr_u   dl_addr,
	input  byte_t      dl_data,
	output bank_mask_t bank_we,
	output bank_addr_t wr_addr,
	output word_t      wr_data
);

	// Program region in slot units
	localparam int unsigned BASE_SLOT = `PROG_BASE_BANK;
	localparam int unsigned LAST_SLOT = BASE_SLOT + `PROG_BANKS - 1;

	logic        accept;     // Byte belongs to the ROM image
	logic        word_done;  // Odd byte closes a word
	logic        in_region;
	int unsigned slot_num;
	int unsigned bank_num;
	bank_mask_t  hit_mask;
	byte_t       prev_byte;  // Even half waiting for its partner

	// ########################################
	// Decode
	// ########################################

	assign accept    = dl_wr && dl_active && (dl_index == 8'd0);
	assign word_done = accept && dl_addr.fld.lane;

	assign slot_num  = 32'(dl_addr.fld.slot);
	assign in_region = (slot_num >= BASE_SLOT) && (slot_num <= LAST_SLOT);
	assign bank_num  = slot_num - BASE_SLOT;  // Only meaningful in region

	// One-hot bank for a slot inside the region
	always_comb begin
		hit_mask = '0;
		for (int i = 0; i < `PROG_BANKS; i++) begin
			hit_mask[i] = in_region && (bank_num == i);
		end
	end

	// ########################################
	// Registers
	// ########################################

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			prev_byte <= '0;
			bank_we   <= '0;
		end else begin
			bank_we <= '0;  // Single cycle pulse
			if (accept)
				prev_byte <= dl_data;  // Any lane refreshes it
			if (word_done)
				bank_we <= hit_mask;
		end
	end

	// Earlier byte lands in the high half
	always_ff @(posedge clk_sys) begin
		if (word_done) begin
			wr_addr <= dl_addr.fld.offset;
			wr_data <= {prev_byte, dl_data};
		end
	end

	// ########################################
	// Checks
	// ########################################

	// At most one bank written at a time
	a_we_onehot: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot0(bank_we));

endmodule

//--- source/prog_rom_pkg.sv
// Program ROM data types and the download address union
`include "prog_rom_macros.svh"

package prog_rom_pkg;

	// ########################################
	// Scalar types
	// ########################################

	typedef logic [7:0]              byte_t;       // Loader byte
	typedef logic [15:0]             word_t;       // CPU program word
	typedef logic [2:0]              bank_idx_t;   // CPU bank slot number
	typedef logic [`PROG_BANKS-1:0]  bank_mask_t;  // One-hot bank write
	typedef logic [`BANK_AW-1:0]     bank_addr_t;  // Word offset in a bank
	typedef logic [`CPU_AW-1:0]      cpu_addr_t;   // CPU word address

	// ########################################
	// Download byte address
	// ########################################

	// Field view of the loader address
	typedef struct packed {
		logic [`SLOT_W-1:0] slot;    // Bank-sized slot in the ROM image
		bank_addr_t         offset;  // Word within the slot
		logic               lane;    // 0 even byte, 1 odd byte
	} dl_fields_t;

	// Same bits seen flat or by field
	typedef union packed {
		logic [`DL_AW-1:0] raw;
		dl_fields_t        fld;
	} dl_addr_u;

endpackage

//--- source/prog_rom_macros.svh
// Program ROM sizing, address widths and download map base
`ifndef PROG_ROM_MACROS_SVH
`define PROG_ROM_MACROS_SVH

// ########################################
// Bank geometry
// ########################################

// Six program banks of equal size
`define PROG_BANKS 6

// Word address width of one bank
// 10 keeps simulation small, 14 gives the 32 KB banks of the board
`define BANK_AW 10

`define BANK_WORDS (1 << `BANK_AW)  // Words per bank

// ########################################
// Address maps
// ########################################

`define DL_AW 25                        // Loader byte address
`define SLOT_W (`DL_AW - `BANK_AW - 1)  // Bank-sized slot field of it

// Slot of program bank 0, the 0x0C0000 region start in bank units
`define PROG_BASE_BANK (32'h0C0000 >> (`BANK_AW + 1))

// CPU word address, eight bank slots
`define CPU_AW (`BANK_AW + 3)

`endif
